// File: run_sim.sh
#!/bin/sh
# build and run the cpu_core testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module cpu_core_tb -Mdir obj_dir -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vcpu_core_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: src.f
verilog/cpu_pkg.sv
verilog/cpu_decode.sv
verilog/cpu_execute.sv
verilog/cpu_result.sv
verilog/cpu_core.sv
tests/cpu_core_tb.sv

// File: tests/cpu_core_tb.sv
`timescale 1ns/10ps

module cpu_core_tb;

    import cpu_pkg::*;

    localparam int MEM_WORDS = 1024;

    logic            clock = 1'b0;
    logic            rst = 1'b1;
    logic [XLEN-1:0] mem_rdata = '0;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic            mem_rw;
    logic            halted;

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    int              store_count = 0;
    int              halt_cycle = 0;
    logic            input_ready = 1'b0;

    cpu_core cpu_core_inst
    (
        .clock     (clock),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rw    (mem_rw),
        .halted    (halted)
    );

    always #10 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] actual,
                              input logic [XLEN-1:0] expected);
        if (actual !== expected)
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
    endtask

    // P preloads memory, S queues an expected store, H gives the halt cycle
    task automatic read_input();
        int              fd;
        int              code;
        string           tag;
        string           rest;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        // unused words read back as the inverted byte address
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = ~(XLEN'(i) << 2);
        fd = $fopen("tests/cpu_input.txt", "r");
        if (fd == 0)
            abort_run("could not open tests/cpu_input.txt");
        while ($fscanf(fd, "%s", tag) == 1)
        begin
            if (tag == "#")
                code = $fgets(rest, fd);
            else if (tag == "P" || tag == "S")
            begin
                code = $fscanf(fd, "%h %h", addr, data);
                if (code != 2)
                    abort_run($sformatf("bad %s record in the input file", tag));
                if (tag == "P")
                    mem[addr[11:2]] = data;
                else
                begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(data);
                end
            end
            else if (tag == "H")
                code = $fscanf(fd, "%d", halt_cycle);
            else
                abort_run($sformatf("unknown record type %s in the input file", tag));
        end
        $fclose(fd);
        if (halt_cycle <= 0)
            abort_run("the input file gives no halt cycle");
    endtask

    task automatic record_store();
        if (store_count >= exp_addr.size())
            abort_run($sformatf("unexpected store of 0x%h to 0x%h after the last expected store",
                                mem_wdata, mem_addr));
        else
        begin
            check_word("mem_addr", mem_addr, exp_addr[store_count]);
            check_word("mem_wdata", mem_wdata, exp_data[store_count]);
            store_count++;
        end
    endtask

    // bus outputs only move on the rising edge, so mid-cycle they are settled
    always @(negedge clock)
    begin
        if (mem_rw === 1'b0)
        begin
            record_store();
            mem[mem_addr[11:2]] = mem_wdata;
        end
        mem_rdata <= mem[mem_addr[11:2]];
    end

    initial
    begin
        wait (input_ready);
        repeat (halt_cycle + 50) @(posedge clock);
        abort_run($sformatf("timeout: core did not finish within %0d cycles", halt_cycle + 50));
    end

    initial
    begin
        read_input();
        input_ready = 1'b1;
        repeat (10) @(negedge clock);
        rst <= 1'b0;

        // three cycles per instruction, so halted must rise on cycle H and not before
        for (int cycle = 1; cycle <= halt_cycle; cycle++)
        begin
            @(negedge clock);
            check_flag("halted", halted, cycle == halt_cycle);
        end

        repeat (12)
        begin
            @(negedge clock);
            check_flag("halted", halted, 1'b1);
            check_flag("mem_rw", mem_rw, 1'b1);
        end

        if (store_count != exp_addr.size())
            abort_run($sformatf("only %0d of %0d expected stores were seen",
                                store_count, exp_addr.size()));
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: tests/cpu_input.txt
# P: byte address, instruction word   S: expected store address, store data
# H: cycles from reset release until halted, three per executed instruction
# constants, r1 built from a low load and a high merge
P 00000000 12341006
P 00000004 A5A59046
P 00000008 0FF02006
P 0000000C 00045006
P 00000010 01007006
P 00000014 000003C7
# add, sub, and, or, xor of r1 and r2, each stored at the next word
P 00000018 00003441
P 0000001C 00007BC1
P 00000020 000007C7
P 00000024 00003442
P 00000028 00007BC1
P 0000002C 000007C7
P 00000030 00003443
P 00000034 00007BC1
P 00000038 000007C7
P 0000003C 00003444
P 00000040 00007BC1
P 00000044 000007C7
P 00000048 00003445
P 0000004C 00007BC1
P 00000050 000007C7
# load the xor result back and store it one word on
P 00000054 000041C8
P 00000058 00007BC1
P 0000005C 000009C7
# cmpeq clear so brf falls through, cmplt set so brf skips 0x78, jmp skips 0x80
P 00000060 00006449
P 00000064 0070018B
P 00000068 00007BC1
P 0000006C 000005C7
P 00000070 0000528A
P 00000074 007C014B
P 00000078 000003C7
P 0000007C 0084000C
P 00000080 000007C7
P 00000084 00000A87
P 00000088 0000000D
S 00000100 A5A51234
S 00000104 A5A52224
S 00000108 A5A50244
S 0000010C 00000230
S 00000110 A5A51FF4
S 00000114 A5A51DC4
S 00000118 A5A51DC4
S 0000011C 00000FF0
S 00000FF0 00000004
H 99

// File: verilog/cpu_core.sv
`timescale 1ns/10ps

module cpu_core
#(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
)
(
    input  logic                      clock,
    input  logic                      rst,
    input  logic [cpu_pkg::XLEN-1:0]  mem_rdata,
    output logic [cpu_pkg::XLEN-1:0]  mem_addr,
    output logic [cpu_pkg::XLEN-1:0]  mem_wdata,
    output logic                      mem_rw,
    output logic                      halted
);

    import cpu_pkg::*;

    phase_t               phase;
    opcode_t              opcode;
    logic [REG_SEL_W-1:0] src_a;
    logic [REG_SEL_W-1:0] src_b;
    logic [REG_SEL_W-1:0] dest;
    logic                 highlow;
    logic [IMM_W-1:0]     imm;
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      rdata_a;
    logic [XLEN-1:0]      rdata_b;
    logic                 flag_a;
    logic [XLEN-1:0]      alu_result;
    logic                 flag_result;
    logic                 redirect;
    logic [XLEN-1:0]      redirect_addr;

    cpu_decode decode_inst
    (
        .clock     (clock),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .rdata_a   (rdata_a),
        .rdata_b   (rdata_b),
        .halted    (halted),
        .phase     (phase),
        .opcode    (opcode),
        .src_a     (src_a),
        .src_b     (src_b),
        .dest      (dest),
        .highlow   (highlow),
        .imm       (imm),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rw    (mem_rw)
    );

    cpu_execute execute_inst
    (
        .opcode        (opcode),
        .rdata_a       (rdata_a),
        .rdata_b       (rdata_b),
        .highlow       (highlow),
        .imm           (imm),
        .flag_a        (flag_a),
        .alu_result    (alu_result),
        .flag_result   (flag_result),
        .redirect      (redirect),
        .redirect_addr (redirect_addr)
    );

    cpu_result #(
        .RESET_PC (RESET_PC)
    ) result_inst
    (
        .clock         (clock),
        .rst           (rst),
        .phase         (phase),
        .opcode        (opcode),
        .src_a         (src_a),
        .src_b         (src_b),
        .dest          (dest),
        .mem_rdata     (mem_rdata),
        .alu_result    (alu_result),
        .flag_result   (flag_result),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .rdata_a       (rdata_a),
        .rdata_b       (rdata_b),
        .pc            (pc),
        .flag_a        (flag_a),
        .halted        (halted)
    );

endmodule

// File: verilog/cpu_decode.sv
`timescale 1ns/10ps

module cpu_decode
(
    input  logic                           clock,
    input  logic                           rst,
    input  logic [cpu_pkg::XLEN-1:0]       mem_rdata,
    input  logic [cpu_pkg::XLEN-1:0]       pc,
    input  logic [cpu_pkg::XLEN-1:0]       rdata_a,
    input  logic [cpu_pkg::XLEN-1:0]       rdata_b,
    input  logic                           halted,
    output cpu_pkg::phase_t                phase,
    output cpu_pkg::opcode_t               opcode,
    output logic [cpu_pkg::REG_SEL_W-1:0]  src_a,
    output logic [cpu_pkg::REG_SEL_W-1:0]  src_b,
    output logic [cpu_pkg::REG_SEL_W-1:0]  dest,
    output logic                           highlow,
    output logic [cpu_pkg::IMM_W-1:0]      imm,
    output logic [cpu_pkg::XLEN-1:0]       mem_addr,
    output logic [cpu_pkg::XLEN-1:0]       mem_wdata,
    output logic                           mem_rw
);

    import cpu_pkg::*;

    logic [XLEN-1:0]     ir;
    logic [OPCODE_W-1:0] raw_op;
    logic                mem_cycle;
    logic                store_cycle;

    // sequencer, parked in fetch once the core has halted
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            phase <= PH_FETCH;
        end
        else
        begin
            case (phase)
                PH_FETCH:
                begin
                    if (!halted)
                        phase <= PH_EXECUTE;
                end
                PH_EXECUTE:
                begin
                    phase <= PH_WRITEBACK;
                end
                default:
                begin
                    phase <= PH_FETCH;
                end
            endcase
        end
    end

    // instruction register, cleared to a nop word
    always_ff @(posedge clock)
    begin
        if (rst)
            ir <= '0;
        else if (phase == PH_FETCH && !halted)
            ir <= mem_rdata;
    end

    assign raw_op  = ir[OPCODE_LSB +: OPCODE_W];
    assign src_a   = ir[SRC_A_LSB +: REG_SEL_W];
    assign src_b   = ir[SRC_B_LSB +: REG_SEL_W];
    assign dest    = ir[DEST_LSB +: REG_SEL_W];
    assign highlow = ir[HIGHLOW_BIT];
    assign imm     = ir[IMM_LSB +: IMM_W];

    // anything past halt decodes as nop
    always_comb
    begin
        if (raw_op <= OP_HALT)
            opcode = opcode_t'(raw_op);
        else
            opcode = OP_NOP;
    end

    assign mem_cycle   = (phase == PH_EXECUTE) && (opcode == OP_LOAD || opcode == OP_STORE);
    assign store_cycle = (phase == PH_EXECUTE) && (opcode == OP_STORE);

    // data accesses use source a as the byte address
    assign mem_addr  = mem_cycle ? rdata_a : pc;
    assign mem_wdata = store_cycle ? rdata_b : '0;
    assign mem_rw    = !store_cycle;

    // a write comes straight after the fetch of a store and lasts one cycle
    a_store_only: assert property (@(posedge clock) disable iff (rst)
        !mem_rw |-> ($past(phase) == PH_FETCH && raw_op == OP_STORE) ##1 mem_rw);

    a_phase_legal: assert property (@(posedge clock) disable iff (rst)
        phase inside {PH_FETCH, PH_EXECUTE, PH_WRITEBACK});

endmodule

// File: verilog/cpu_execute.sv
`timescale 1ns/10ps

module cpu_execute
(
    input  cpu_pkg::opcode_t             opcode,
    input  logic [cpu_pkg::XLEN-1:0]     rdata_a,
    input  logic [cpu_pkg::XLEN-1:0]     rdata_b,
    input  logic                         highlow,
    input  logic [cpu_pkg::IMM_W-1:0]    imm,
    input  logic                         flag_a,
    output logic [cpu_pkg::XLEN-1:0]     alu_result,
    output logic                         flag_result,
    output logic                         redirect,
    output logic [cpu_pkg::XLEN-1:0]     redirect_addr
);

    import cpu_pkg::*;

    logic [XLEN-1:0] imm_zext;
    logic [XLEN-1:0] imm_high;

    assign imm_zext = {{(XLEN-IMM_W){1'b0}}, imm};

    // high load keeps the low half of source a
    assign imm_high = {imm, rdata_a[XLEN-IMM_W-1:0]};

    always_comb
    begin
        case (opcode)
            OP_ADD:
            begin
                alu_result = rdata_a + rdata_b;
            end
            OP_SUB:
            begin
                alu_result = rdata_a - rdata_b;
            end
            OP_AND:
            begin
                alu_result = rdata_a & rdata_b;
            end
            OP_OR:
            begin
                alu_result = rdata_a | rdata_b;
            end
            OP_XOR:
            begin
                alu_result = rdata_a ^ rdata_b;
            end
            OP_LDI:
            begin
                alu_result = highlow ? imm_high : imm_zext;
            end
            default:
            begin
                alu_result = '0;
            end
        endcase
    end

    // compares are unsigned
    always_comb
    begin
        case (opcode)
            OP_CMPEQ: flag_result = (rdata_a == rdata_b);
            OP_CMPLT: flag_result = (rdata_a < rdata_b);
            default:  flag_result = 1'b0;
        endcase
    end

    always_comb
    begin
        case (opcode)
            OP_BRF:  redirect = flag_a;
            OP_JMP:  redirect = 1'b1;
            default: redirect = 1'b0;
        endcase
    end

    // both control transfers go to an absolute byte address
    assign redirect_addr = imm_zext;

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

    // datapath and instruction word widths
    localparam int XLEN      = 32;
    localparam int REG_SEL_W = 3;
    localparam int IMM_W     = 16;
    localparam int OPCODE_W  = 6;

    // field positions inside the instruction word
    localparam int OPCODE_LSB  = 0;
    localparam int SRC_A_LSB   = 6;
    localparam int SRC_B_LSB   = 9;
    localparam int DEST_LSB    = 12;
    localparam int HIGHLOW_BIT = 15;
    localparam int IMM_LSB     = 16;

    typedef enum logic [OPCODE_W-1:0]
    {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_LDI   = 6'd6,
        OP_STORE = 6'd7,
        OP_LOAD  = 6'd8,
        OP_CMPEQ = 6'd9,
        OP_CMPLT = 6'd10,
        OP_BRF   = 6'd11,
        OP_JMP   = 6'd12,
        OP_HALT  = 6'd13
    } opcode_t;

    // one pass through these three states per instruction
    typedef enum logic [1:0]
    {
        PH_FETCH     = 2'd0,
        PH_EXECUTE   = 2'd1,
        PH_WRITEBACK = 2'd2
    } phase_t;

endpackage

// File: verilog/cpu_result.sv
`timescale 1ns/10ps

module cpu_result
#(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
)
(
    input  logic                           clock,
    input  logic                           rst,
    input  cpu_pkg::phase_t                phase,
    input  cpu_pkg::opcode_t               opcode,
    input  logic [cpu_pkg::REG_SEL_W-1:0]  src_a,
    input  logic [cpu_pkg::REG_SEL_W-1:0]  src_b,
    input  logic [cpu_pkg::REG_SEL_W-1:0]  dest,
    input  logic [cpu_pkg::XLEN-1:0]       mem_rdata,
    input  logic [cpu_pkg::XLEN-1:0]       alu_result,
    input  logic                           flag_result,
    input  logic                           redirect,
    input  logic [cpu_pkg::XLEN-1:0]       redirect_addr,
    output logic [cpu_pkg::XLEN-1:0]       rdata_a,
    output logic [cpu_pkg::XLEN-1:0]       rdata_b,
    output logic [cpu_pkg::XLEN-1:0]       pc,
    output logic                           flag_a,
    output logic                           halted
);

    import cpu_pkg::*;

    localparam int NUM_REGS = 1 << REG_SEL_W;

    logic [XLEN-1:0]     regs [NUM_REGS];
    logic [NUM_REGS-1:0] flags;
    logic [XLEN-1:0]     load_data;
    logic                wb;

    assign wb = (phase == PH_WRITEBACK);

    assign rdata_a = regs[src_a];
    assign rdata_b = regs[src_b];
    assign flag_a  = flags[src_a];

    // memory answers in the execute cycle, written back one cycle later
    always_ff @(posedge clock)
    begin
        if (phase == PH_EXECUTE && opcode == OP_LOAD)
            load_data <= mem_rdata;
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
            flags <= '0;
        end
        else if (wb)
        begin
            case (opcode)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI:
                begin
                    regs[dest] <= alu_result;
                end
                OP_LOAD:
                begin
                    regs[dest] <= load_data;
                end
                OP_CMPEQ, OP_CMPLT:
                begin
                    flags[dest] <= flag_result;
                end
                default:
                begin
                end
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end
        else if (wb)
        begin
            pc <= redirect ? redirect_addr : pc + XLEN'(4);
            if (opcode == OP_HALT)
                halted <= 1'b1;
        end
    end

    // jump and branch targets come from the immediate, so this also checks the program
    a_pc_aligned: assert property (@(posedge clock) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule
